/* design/synth_pkg.sv */
/*
 * shared synth definitions: midi byte union, note message codes,
 * key / velocity / sample widths, cpu register addresses
 */
package synth_pkg;

    //////////////////////////////////////////////////
    // midi byte, one wire word seen two ways
    typedef union packed {
        struct packed {
            logic       marker;     // 1 on a status byte
            logic [2:0] msg_type;   // upper nibble without the marker
            logic [3:0] channel;    // midi channel 0..15
        } status;
        struct packed {
            logic       marker;     // 0 on a data byte
            logic [6:0] value;      // key number or velocity
        } data;
    } midi_byte_t;

    // message type codes as seen in the status view
    localparam logic [2:0] MSG_NOTE_OFF = 3'd0;   // 0x8n
    localparam logic [2:0] MSG_NOTE_ON  = 3'd1;   // 0x9n

    //////////////////////////////////////////////////
    // datapath widths
    localparam int KEY_W    = 7;    // midi key number
    localparam int VEL_W    = 7;    // midi velocity
    localparam int SAMPLE_W = 16;   // signed audio sample

    //////////////////////////////////////////////////
    // cpu register map
    localparam logic [1:0] REG_ADDR_CHANNEL = 2'd0;   // r/w, low nibble
    localparam logic [1:0] REG_ADDR_KEYS_ON = 2'd1;   // ro, one bit per voice
    localparam logic [1:0] REG_ADDR_DROPS   = 2'd2;   // ro, saturating

endpackage

/* design/midi_uart_rx.sv */
/*
 * midi serial receiver: 2-flop input sync, start bit check,
 * mid-bit sampling, lsb first shift, stop bit check
 */
`timescale 1ns/1ps

module midi_uart_rx #(
    parameter int CLKS_PER_BIT = 1600
) (
    input  logic       CLOCK_50,
    input  logic       io_reset,
    input  logic       midi_rxd,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    // receiver states
    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic             rxd_meta;
    logic             rxd_sync;
    logic [1:0]       state;
    logic [CNT_W-1:0] bit_cnt;   // clocks into current bit
    logic [2:0]       bit_idx;   // data bit number
    logic [7:0]       shift;

    // line idles high, so sync flops come out of reset high
    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= midi_rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;   // single cycle strobe
            case (state)
                S_IDLE: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (!rxd_sync) state <= S_START;   // falling edge
                end
                S_START: begin
                    if (bit_cnt == HALF_BIT) begin
                        bit_cnt <= '0;
                        state   <= rxd_sync ? S_IDLE : S_DATA;   // glitch check
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_cnt == FULL_BIT) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= S_STOP;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin   // S_STOP, sampled mid bit
                    if (bit_cnt == FULL_BIT) begin
                        state    <= S_IDLE;
                        rx_valid <= rxd_sync;   // framing error gives no strobe
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge CLOCK_50) begin
        if (state == S_DATA && bit_cnt == FULL_BIT) shift <= {rxd_sync, shift[7:1]};
    end

    assign rx_byte = shift;   // stable until next data bit

endmodule

/* design/midi_parser.sv */
/*
 * midi message parser: status / data byte fsm, channel filter,
 * note-on and note-off event pulses with key and velocity
 */
`timescale 1ns/1ps

module midi_parser (
    input  logic                       CLOCK_50,
    input  logic                       io_reset,
    input  logic [7:0]                 rx_byte,
    input  logic                       rx_valid,
    input  logic [3:0]                 midi_ch,
    output logic                       note_on_evt,
    output logic                       note_off_evt,
    output logic [synth_pkg::KEY_W-1:0] evt_key,
    output logic [synth_pkg::VEL_W-1:0] evt_vel
);

    // parser states
    localparam logic [1:0] P_IDLE = 2'd0;   // disarmed, data bytes dropped
    localparam logic [1:0] P_KEY  = 2'd1;   // waiting for key byte
    localparam logic [1:0] P_VEL  = 2'd2;   // waiting for velocity byte

    synth_pkg::midi_byte_t             in_byte;
    logic                              note_status;   // note msg on our channel
    logic                              vel_zero;
    logic [1:0]                        state;
    logic                              msg_on;        // armed by a note-on status
    logic [synth_pkg::KEY_W-1:0]       key_hold;

    assign in_byte = rx_byte;

    always_comb begin
        note_status = 1'b0;
        if (in_byte.status.msg_type == synth_pkg::MSG_NOTE_ON ||
            in_byte.status.msg_type == synth_pkg::MSG_NOTE_OFF) begin
            note_status = (in_byte.status.channel == midi_ch);
        end
    end

    assign vel_zero = (in_byte.data.value == '0);   // note-on vel 0 means release

    //////////////////////////////////////////////////
    // byte sequencing
    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            state        <= P_IDLE;
            msg_on       <= 1'b0;
            note_on_evt  <= 1'b0;
            note_off_evt <= 1'b0;
        end else begin
            note_on_evt  <= 1'b0;
            note_off_evt <= 1'b0;
            if (rx_valid) begin
                if (in_byte.status.marker) begin
                    // any status byte rearms or disarms
                    if (note_status) begin
                        state  <= P_KEY;
                        msg_on <= (in_byte.status.msg_type == synth_pkg::MSG_NOTE_ON);
                    end else begin
                        state <= P_IDLE;
                    end
                end else begin
                    case (state)
                        P_KEY: state <= P_VEL;
                        P_VEL: begin
                            state        <= P_IDLE;   // no running status
                            note_on_evt  <= msg_on && !vel_zero;
                            note_off_evt <= !msg_on || vel_zero;
                        end
                        default: state <= P_IDLE;   // stray data byte
                    endcase
                end
            end
        end
    end

    // key and velocity capture, held through the event pulse
    always_ff @(posedge CLOCK_50) begin
        if (rx_valid && !in_byte.data.marker) begin
            if (state == P_KEY) key_hold <= in_byte.data.value;
            if (state == P_VEL) begin
                evt_key <= key_hold;
                evt_vel <= in_byte.data.value;
            end
        end
    end

endmodule

/* design/voice_table.sv */
/*
 * voice allocation table: key, velocity and active flag per voice,
 * lowest free voice allocation, release by key, dropped-note pulse
 */
`timescale 1ns/1ps

module voice_table #(
    parameter int VOICES = 4
) (
    input  logic                                CLOCK_50,
    input  logic                                io_reset,
    input  logic                                note_on_evt,
    input  logic                                note_off_evt,
    input  logic [synth_pkg::KEY_W-1:0]         evt_key,
    input  logic [synth_pkg::VEL_W-1:0]         evt_vel,
    output logic [VOICES-1:0]                   keys_on,
    output logic [VOICES*synth_pkg::KEY_W-1:0]  voice_keys,
    output logic [VOICES*synth_pkg::VEL_W-1:0]  voice_vels,
    output logic                                note_dropped
);

    localparam int KW = synth_pkg::KEY_W;
    localparam int VW = synth_pkg::VEL_W;

    logic [VOICES-1:0] hit;      // active voices holding evt_key
    logic [VOICES-1:0] free_v;   // idle voices
    logic [VOICES-1:0] alloc;    // lowest idle voice, one-hot
    logic [VOICES-1:0] target;   // voice written by a note-on
    logic              any_hit;

    //////////////////////////////////////////////////
    // key match and free voice search
    always_comb begin
        for (int i = 0; i < VOICES; i++) begin
            hit[i] = keys_on[i] && (voice_keys[i*KW +: KW] == evt_key);
        end
    end

    assign any_hit = |hit;
    assign free_v  = ~keys_on;
    assign alloc   = free_v & (~free_v + 1'b1);   // isolate lowest set bit
    assign target  = any_hit ? hit : alloc;       // retrigger keeps its voice

    //////////////////////////////////////////////////
    // active flags and overflow
    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            keys_on      <= '0;
            note_dropped <= 1'b0;
        end else begin
            note_dropped <= note_on_evt && !any_hit && (free_v == '0);   // table full
            if (note_on_evt) begin
                keys_on <= keys_on | target;   // no-op when full
            end else if (note_off_evt) begin
                keys_on <= keys_on & ~hit;     // unheld key leaves hit empty
            end
        end
    end

    // per voice key and velocity
    always_ff @(posedge CLOCK_50) begin
        for (int i = 0; i < VOICES; i++) begin
            if (note_on_evt && target[i]) begin
                voice_keys[i*KW +: KW] <= evt_key;
                voice_vels[i*VW +: VW] <= evt_vel;   // refresh on retrigger
            end
        end
    end

endmodule

/* design/tone_mixer.sv */
/*
 * square-wave tone mixer: sample divider, per-voice phase
 * accumulators, signed sum of active voices
 */
`timescale 1ns/1ps

module tone_mixer #(
    parameter int VOICES     = 4,
    parameter int SAMPLE_DIV = 1024
) (
    input  logic                                CLOCK_50,
    input  logic                                io_reset,
    input  logic [VOICES-1:0]                   keys_on,
    input  logic [VOICES*synth_pkg::KEY_W-1:0]  voice_keys,
    input  logic [VOICES*synth_pkg::VEL_W-1:0]  voice_vels,
    output logic signed [synth_pkg::SAMPLE_W-1:0] sound_out,
    output logic                                sample_strobe
);

    localparam int KW      = synth_pkg::KEY_W;
    localparam int VW      = synth_pkg::VEL_W;
    localparam int SW      = synth_pkg::SAMPLE_W;
    localparam int PHASE_W = 16;
    localparam int DIV_W   = (SAMPLE_DIV > 2) ? $clog2(SAMPLE_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SAMPLE_DIV - 1);

    logic [DIV_W-1:0]   div_cnt;
    logic               tick;              // last clock of a sample period
    logic [PHASE_W-1:0] phase [VOICES];
    logic signed [SW-1:0] mix;

    //////////////////////////////////////////////////
    // sample rate divider
    assign tick = (div_cnt == DIV_LAST);

    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            div_cnt       <= '0;
            sample_strobe <= 1'b0;
        end else begin
            div_cnt       <= tick ? '0 : div_cnt + 1'b1;
            sample_strobe <= tick;   // lines up with the new sound_out
        end
    end

    // phase step is key + 1, so key 0 still moves
    always_ff @(posedge CLOCK_50) begin
        for (int i = 0; i < VOICES; i++) begin
            if (io_reset || !keys_on[i]) begin
                phase[i] <= '0;   // idle voice restarts at the top half
            end else if (tick) begin
                phase[i] <= phase[i] + PHASE_W'(voice_keys[i*KW +: KW]) + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // mixer, amplitude is velocity x 16
    always_comb begin
        logic signed [SW-1:0] amp;
        mix = '0;
        for (int i = 0; i < VOICES; i++) begin
            amp = SW'({voice_vels[i*VW +: VW], 4'b0000});
            if (keys_on[i]) mix = phase[i][PHASE_W-1] ? mix - amp : mix + amp;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (io_reset) sound_out <= '0;
        else if (tick) sound_out <= mix;   // held between strobes
    end

endmodule

/* design/synth_regs.sv */
/*
 * cpu register block: channel register, keys_on readback,
 * saturating dropped-note counter
 */
`timescale 1ns/1ps

module synth_regs #(
    parameter int VOICES = 4
) (
    input  logic              CLOCK_50,
    input  logic              io_reset,
    input  logic              cpu_read,
    input  logic              cpu_write,
    input  logic [1:0]        address,
    input  logic [7:0]        writedata,
    input  logic [VOICES-1:0] keys_on,
    input  logic              note_dropped,
    output logic [7:0]        readdata,
    output logic [3:0]        midi_ch
);

    logic [7:0] drop_cnt;

    // only the channel register is writable
    always_ff @(posedge CLOCK_50) begin
        if (io_reset) midi_ch <= '0;
        else if (cpu_write && address == synth_pkg::REG_ADDR_CHANNEL) midi_ch <= writedata[3:0];
    end

    always_ff @(posedge CLOCK_50) begin
        if (io_reset) drop_cnt <= '0;
        else if (note_dropped && drop_cnt != 8'hff) drop_cnt <= drop_cnt + 1'b1;   // sticks at 255
    end

    // read mux, data shows up the cycle after cpu_read
    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            readdata <= '0;
        end else if (cpu_read) begin
            case (address)
                synth_pkg::REG_ADDR_CHANNEL: readdata <= {4'b0000, midi_ch};
                synth_pkg::REG_ADDR_KEYS_ON: readdata <= 8'(keys_on);
                synth_pkg::REG_ADDR_DROPS:   readdata <= drop_cnt;
                default:                     readdata <= '0;   // unmapped
            endcase
        end
    end

endmodule

/* design/synthesizer.sv */
/*
 * synth top: midi receiver, parser, voice table, tone mixer, cpu registers
 */
`timescale 1ns/1ps

module synthesizer #(
    parameter int VOICES       = 4,
    parameter int CLKS_PER_BIT = 1600,   // 50 MHz / 31250 baud
    parameter int SAMPLE_DIV   = 1024
) (
    input  logic                                  CLOCK_50,
    input  logic                                  io_reset,
    input  logic                                  midi_rxd,
    input  logic                                  cpu_read,
    input  logic                                  cpu_write,
    input  logic [1:0]                            address,
    input  logic [7:0]                            writedata,
    output logic [7:0]                            readdata,
    output logic [VOICES-1:0]                     keys_on,
    output logic signed [synth_pkg::SAMPLE_W-1:0] sound_out,
    output logic                                  sample_strobe
);

    logic [7:0]                               rx_byte;
    logic                                     rx_valid;
    logic [3:0]                               midi_ch;
    logic                                     note_on_evt;
    logic                                     note_off_evt;
    logic [synth_pkg::KEY_W-1:0]              evt_key;
    logic [synth_pkg::VEL_W-1:0]              evt_vel;
    logic [VOICES*synth_pkg::KEY_W-1:0]       voice_keys;
    logic [VOICES*synth_pkg::VEL_W-1:0]       voice_vels;
    logic                                     note_dropped;

    //////////////////////////////////////////////////
    // midi input path
    midi_uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .CLOCK_50(CLOCK_50), .io_reset(io_reset), .midi_rxd(midi_rxd),
        .rx_byte(rx_byte), .rx_valid(rx_valid)
    );

    midi_parser u_parser (
        .CLOCK_50(CLOCK_50), .io_reset(io_reset),
        .rx_byte(rx_byte), .rx_valid(rx_valid), .midi_ch(midi_ch),
        .note_on_evt(note_on_evt), .note_off_evt(note_off_evt),
        .evt_key(evt_key), .evt_vel(evt_vel)
    );

    //////////////////////////////////////////////////
    // voices and audio
    voice_table #(.VOICES(VOICES)) u_voices (
        .CLOCK_50(CLOCK_50), .io_reset(io_reset),
        .note_on_evt(note_on_evt), .note_off_evt(note_off_evt),
        .evt_key(evt_key), .evt_vel(evt_vel),
        .keys_on(keys_on), .voice_keys(voice_keys), .voice_vels(voice_vels),
        .note_dropped(note_dropped)
    );

    tone_mixer #(.VOICES(VOICES), .SAMPLE_DIV(SAMPLE_DIV)) u_mixer (
        .CLOCK_50(CLOCK_50), .io_reset(io_reset),
        .keys_on(keys_on), .voice_keys(voice_keys), .voice_vels(voice_vels),
        .sound_out(sound_out), .sample_strobe(sample_strobe)
    );

    // cpu side
    synth_regs #(.VOICES(VOICES)) u_regs (
        .CLOCK_50(CLOCK_50), .io_reset(io_reset),
        .cpu_read(cpu_read), .cpu_write(cpu_write), .address(address),
        .writedata(writedata), .keys_on(keys_on), .note_dropped(note_dropped),
        .readdata(readdata), .midi_ch(midi_ch)
    );

endmodule

/* test/tb_synthesizer.sv */
/*
 * synthesizer testbench: clock, reset, uart byte driver, lfsr stimulus,
 * cpu bus tasks, voice table model, concurrent checks on keys, regs, audio
 */
`timescale 1ns/1ps

module tb_synthesizer;

    localparam int VOICES       = 4;
    localparam int CLKS_PER_BIT = 16;
    localparam int SAMPLE_DIV   = 32;
    localparam int KEYS_TIMEOUT = 4 * CLKS_PER_BIT;   // cycles after last stop bit

    logic                 CLOCK_50;
    logic                 io_reset;
    logic                 midi_rxd;
    logic                 cpu_read;
    logic                 cpu_write;
    logic [1:0]           address;
    logic [7:0]           writedata;
    logic [7:0]           readdata;
    logic [VOICES-1:0]    keys_on;
    logic signed [synth_pkg::SAMPLE_W-1:0] sound_out;
    logic                 sample_strobe;

    // check enables and expected values
    logic                 check_keys;
    logic [VOICES-1:0]    exp_keys;
    logic                 rst_check;
    logic                 rd_check;
    logic [7:0]           rd_exp;
    logic [1:0]           audio_mode;   // 0 off, 1 silence, 2 single tone
    logic signed [synth_pkg::SAMPLE_W-1:0] amp_exp;
    int                   strobe_gap;   // clocks since last strobe, 0 until the first
    int                   errors;

    // voice table model
    logic                 model_on  [VOICES];
    logic [6:0]           model_key [VOICES];
    logic [6:0]           model_vel [VOICES];
    int                   model_drops;
    logic [3:0]           prog_ch;
    logic [7:0]           lfsr;

    synthesizer #(
        .VOICES(VOICES), .CLKS_PER_BIT(CLKS_PER_BIT), .SAMPLE_DIV(SAMPLE_DIV)
    ) u_dut (
        .CLOCK_50(CLOCK_50), .io_reset(io_reset), .midi_rxd(midi_rxd),
        .cpu_read(cpu_read), .cpu_write(cpu_write), .address(address),
        .writedata(writedata), .readdata(readdata), .keys_on(keys_on),
        .sound_out(sound_out), .sample_strobe(sample_strobe)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;   // 125 MHz sim clock
    end

    //////////////////////////////////////////////////
    // failure reporting
    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic fail_plain(input string why);
        errors++;
        $display("%s", why);
        stop_with_failure();
    endtask

    // sample strobe spacing
    always @(posedge CLOCK_50) begin
        if (io_reset) strobe_gap <= 0;
        else if (sample_strobe) strobe_gap <= 1;
        else if (strobe_gap != 0) strobe_gap <= strobe_gap + 1;
    end

    //////////////////////////////////////////////////
    // concurrent checks
    reset_zero: assert property (@(posedge CLOCK_50)
        rst_check |-> (keys_on == '0 && sound_out == '0 && readdata == '0))
        else mismatch("outputs not zero around reset");

    keys_match: assert property (@(posedge CLOCK_50) check_keys |-> (keys_on == exp_keys))
        else mismatch($sformatf("keys_on %b, model %b", keys_on, exp_keys));

    read_match: assert property (@(posedge CLOCK_50) rd_check |-> (readdata == rd_exp))
        else mismatch($sformatf("readdata %h, expected %h", readdata, rd_exp));

    strobe_period: assert property (@(posedge CLOCK_50) (strobe_gap != 0) |->
        (sample_strobe ? strobe_gap == SAMPLE_DIV : strobe_gap < SAMPLE_DIV))
        else mismatch($sformatf("sample_strobe spacing wrong, %0d clocks since the last one",
                                strobe_gap));

    silence: assert property (@(posedge CLOCK_50)
        (audio_mode == 2'd1 && sample_strobe) |-> (sound_out == '0))
        else mismatch($sformatf("sound_out %0d with no voice active", sound_out));

    one_tone: assert property (@(posedge CLOCK_50)
        (audio_mode == 2'd2 && sample_strobe) |-> (sound_out == amp_exp || sound_out == -amp_exp))
        else mismatch($sformatf("sound_out %0d, magnitude should be %0d", sound_out, amp_exp));

    //////////////////////////////////////////////////
    // lfsr stimulus
    function automatic logic [7:0] galois_step(input logic [7:0] s);
        galois_step = s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);   // x^8+x^6+x^5+x^4+1
    endfunction

    task automatic take_bits(input int n, output logic [6:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = galois_step(lfsr);
            v = {v[5:0], lfsr[0]};   // one step per bit
        end
    endtask

    task automatic rand_vel(output logic [6:0] v);
        take_bits(7, v);
        if (v == '0) v = 7'd1;   // vel 0 would be a release
    endtask

    // key not held by any model voice
    task automatic fresh_key(output logic [6:0] k);
        logic [6:0] cand;
        logic       used;
        logic       found;
        found = 1'b0;
        k = '0;
        for (int t = 0; t < 64 && !found; t++) begin
            take_bits(7, cand);
            used = 1'b0;
            for (int i = 0; i < VOICES; i++) used |= model_on[i] && model_key[i] == cand;
            if (!used) begin
                k = cand;
                found = 1'b1;
            end
        end
        if (!found) fail_plain("could not draw an unused random key");
    endtask

    //////////////////////////////////////////////////
    // voice table model
    task automatic model_note_on(input logic [6:0] k, input logic [6:0] v);
        logic held;
        int   free_idx;
        held = 1'b0;
        free_idx = -1;
        for (int i = 0; i < VOICES; i++) begin
            if (model_on[i] && model_key[i] == k) begin
                model_vel[i] = v;   // retrigger, same voice
                held = 1'b1;
            end
        end
        for (int i = VOICES - 1; i >= 0; i--) if (!model_on[i]) free_idx = i;   // lowest free
        if (!held && free_idx < 0) begin
            if (model_drops < 255) model_drops++;
        end else if (!held) begin
            model_on[free_idx]  = 1'b1;
            model_key[free_idx] = k;
            model_vel[free_idx] = v;
        end
    endtask

    task automatic model_note_off(input logic [6:0] k);
        for (int i = 0; i < VOICES; i++) if (model_on[i] && model_key[i] == k) model_on[i] = 1'b0;
    endtask

    function automatic logic [VOICES-1:0] model_mask();
        for (int i = 0; i < VOICES; i++) model_mask[i] = model_on[i];
    endfunction

    //////////////////////////////////////////////////
    // bus and line drivers, all at edge + 1 ns
    task automatic tick_cycles(input int n);
        repeat (n) @(posedge CLOCK_50);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] b);
        midi_rxd = 1'b0;   // start bit
        tick_cycles(CLKS_PER_BIT);
        for (int i = 0; i < 8; i++) begin
            midi_rxd = b[i];   // lsb first
            tick_cycles(CLKS_PER_BIT);
        end
        midi_rxd = 1'b1;   // stop bit, then idle
        tick_cycles(CLKS_PER_BIT);
    endtask

    task automatic wait_keys();
        for (int n = 0; n < KEYS_TIMEOUT && keys_on != exp_keys; n++) tick_cycles(1);
        if (keys_on != exp_keys) fail_plain("timeout waiting for keys_on to follow the note message");
    endtask

    task automatic wait_strobes(input int count);
        int seen;
        int n;
        seen = 0;
        n = 0;
        while (seen < count && n < count * (SAMPLE_DIV + 8)) begin
            tick_cycles(1);
            n++;
            if (sample_strobe) seen++;
        end
        if (seen < count) fail_plain("timeout waiting for sample_strobe");
    endtask

    task automatic send_note(input logic [2:0] mtype, input logic [3:0] ch,
                             input logic [6:0] k, input logic [6:0] v);
        synth_pkg::midi_byte_t sb;
        synth_pkg::midi_byte_t kb;
        synth_pkg::midi_byte_t vb;
        sb.status.marker   = 1'b1;
        sb.status.msg_type = mtype;
        sb.status.channel  = ch;
        kb.data.marker = 1'b0;
        kb.data.value  = k;
        vb.data.marker = 1'b0;
        vb.data.value  = v;
        check_keys = 1'b0;   // keys may move while bytes are in flight
        send_byte(sb);
        send_byte(kb);
        send_byte(vb);
        if (ch == prog_ch) begin
            if (mtype == synth_pkg::MSG_NOTE_ON && v != '0) model_note_on(k, v);
            else model_note_off(k);
        end
        exp_keys = model_mask();
        wait_keys();
        check_keys = 1'b1;
        tick_cycles(2 * CLKS_PER_BIT);   // quiet gap, keys must hold
    endtask

    task automatic cpu_write_reg(input logic [1:0] a, input logic [7:0] d);
        address   = a;
        writedata = d;
        cpu_write = 1'b1;
        tick_cycles(1);
        cpu_write = 1'b0;
    endtask

    task automatic cpu_read_check(input logic [1:0] a, input logic [7:0] exp);
        address  = a;
        cpu_read = 1'b1;
        tick_cycles(1);
        cpu_read = 1'b0;
        rd_exp   = exp;
        rd_check = 1'b1;   // checked on the following edge
        tick_cycles(1);
        rd_check = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // test sequence
    initial begin
        logic [6:0] keys [6];
        logic [6:0] vel;
        io_reset  = 1'b1;
        midi_rxd  = 1'b1;
        cpu_read  = 1'b0;
        cpu_write = 1'b0;
        address   = '0;
        writedata = '0;
        check_keys = 1'b0;
        exp_keys   = '0;
        rst_check  = 1'b0;
        rd_check   = 1'b0;
        rd_exp     = '0;
        audio_mode = 2'd0;
        amp_exp    = '0;
        errors     = 0;
        lfsr       = 8'd66;
        prog_ch    = '0;
        model_drops = 0;
        for (int i = 0; i < VOICES; i++) begin
            model_on[i]  = 1'b0;
            model_key[i] = '0;
            model_vel[i] = '0;
        end

        // reset for 5 edges, checked through one cycle after release
        tick_cycles(1);
        rst_check = 1'b1;
        tick_cycles(4);
        io_reset = 1'b0;
        tick_cycles(2);
        rst_check  = 1'b0;
        check_keys = 1'b1;

        audio_mode = 2'd1;   // idle output is silent
        wait_strobes(3);
        audio_mode = 2'd0;

        // register map, ro addresses ignore writes
        cpu_write_reg(synth_pkg::REG_ADDR_CHANNEL, 8'ha5);
        prog_ch = 4'h5;
        cpu_read_check(synth_pkg::REG_ADDR_CHANNEL, 8'h05);
        cpu_write_reg(synth_pkg::REG_ADDR_KEYS_ON, 8'hff);
        cpu_write_reg(synth_pkg::REG_ADDR_DROPS, 8'hff);
        cpu_read_check(synth_pkg::REG_ADDR_CHANNEL, 8'h05);
        cpu_read_check(synth_pkg::REG_ADDR_KEYS_ON, 8'h00);
        cpu_read_check(synth_pkg::REG_ADDR_DROPS, 8'h00);
        cpu_write_reg(synth_pkg::REG_ADDR_CHANNEL, 8'h09);
        prog_ch = 4'h9;
        cpu_read_check(synth_pkg::REG_ADDR_CHANNEL, 8'h09);

        //////////////////////////////////////////////////
        // single voice tone, then retrigger at a new velocity
        fresh_key(keys[0]);
        rand_vel(vel);
        send_note(synth_pkg::MSG_NOTE_ON, prog_ch, keys[0], vel);
        wait_strobes(1);
        amp_exp = 16'(vel) * 16'd16;   // velocity x 16
        audio_mode = 2'd2;
        wait_strobes(4);
        audio_mode = 2'd0;
        rand_vel(vel);
        send_note(synth_pkg::MSG_NOTE_ON, prog_ch, keys[0], vel);
        wait_strobes(1);
        amp_exp = 16'(vel) * 16'd16;
        audio_mode = 2'd2;
        wait_strobes(3);
        audio_mode = 2'd0;

        // other channel and a stray data byte are ignored
        fresh_key(keys[1]);
        send_note(synth_pkg::MSG_NOTE_ON, prog_ch ^ 4'h4, keys[1], vel);
        send_byte(8'h3c);
        tick_cycles(2 * CLKS_PER_BIT);

        // fill all voices, fifth note overflows
        for (int i = 1; i < 5; i++) begin
            fresh_key(keys[i]);
            rand_vel(vel);
            send_note(synth_pkg::MSG_NOTE_ON, prog_ch, keys[i], vel);
        end
        cpu_read_check(synth_pkg::REG_ADDR_KEYS_ON, 8'(model_mask()));
        cpu_read_check(synth_pkg::REG_ADDR_DROPS, 8'(model_drops));

        // note-off, vel 0 release, unheld key, reuse of lowest voice
        send_note(synth_pkg::MSG_NOTE_OFF, prog_ch, keys[2], 7'd64);
        send_note(synth_pkg::MSG_NOTE_ON, prog_ch, keys[0], 7'd0);
        send_note(synth_pkg::MSG_NOTE_OFF, prog_ch, keys[4], 7'd0);
        fresh_key(keys[5]);
        rand_vel(vel);
        send_note(synth_pkg::MSG_NOTE_ON, prog_ch, keys[5], vel);
        cpu_read_check(synth_pkg::REG_ADDR_KEYS_ON, 8'(model_mask()));

        for (int i = 0; i < 6; i++) send_note(synth_pkg::MSG_NOTE_OFF, prog_ch, keys[i], 7'd0);
        wait_strobes(1);
        audio_mode = 2'd1;
        wait_strobes(3);
        audio_mode = 2'd0;
        tick_cycles(4);

        if (errors == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

/* synthesizer.f */
design/synth_pkg.sv
design/midi_uart_rx.sv
design/midi_parser.sv
design/voice_table.sv
design/tone_mixer.sv
design/synth_regs.sv
design/synthesizer.sv
test/tb_synthesizer.sv

/* Makefile */
# Verilator flow for the synthesizer testbench

VERILATOR  ?= verilator
TOP        := tb_synthesizer
FILELIST   := synthesizer.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation completed successfully
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
